/* rtl/rab_pkg.sv */
package rab_pkg;

  localparam int VIRT_ADDR_WIDTH = 32;
  localparam int PHYS_ADDR_WIDTH = 40;
  localparam int WB_DATA_WIDTH   = 64; // one slice register per word
  localparam int WB_ADDR_WIDTH   = 8;  // word address
  localparam int USER_WIDTH      = 6;
  localparam int REGS_PER_SLICE  = 4;

  typedef logic [VIRT_ADDR_WIDTH-1:0] virt_addr_t;
  typedef logic [PHYS_ADDR_WIDTH-1:0] phys_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0]   wb_data_t;
  typedef logic [WB_ADDR_WIDTH-1:0]   wb_addr_t;
  typedef logic [USER_WIDTH-1:0]      user_t;
  typedef logic [7:0]                 burst_len_t;  // beats minus one
  typedef logic [2:0]                 beat_size_t;  // log2 of bytes per beat

  // register index inside a slice, word address is 4*slice + field
  localparam int SLICE_START  = 0;
  localparam int SLICE_END    = 1;
  localparam int SLICE_OFFSET = 2;
  localparam int SLICE_FLAGS  = 3;

  // bits of the flags register
  localparam int FLAG_EN = 0;
  localparam int FLAG_RD = 1;
  localparam int FLAG_WR = 2;

  typedef enum logic [1:0]
  {
    IDLE,
    DECIDE,
    WAIT_SENT
  } fsm_state_t;

endpackage

/* rtl/rab_cfg_regs.sv */
module rab_cfg_regs
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  logic     Clk_CI,
  input  logic     Rst_RBI,
  input  logic     wb_cyc,
  input  logic     wb_stb,
  input  logic     wb_we,
  input  wb_addr_t wb_adr,
  input  wb_data_t wb_dat_w,
  output wb_data_t wb_dat_r,
  output logic     wb_ack,
  output wb_data_t slice_regs [REGS_PER_SLICE*N_SLICES]
);

  localparam int N_REGS = REGS_PER_SLICE * N_SLICES;
  localparam int IDX_W  = $clog2(N_REGS);

  logic             wb_req;
  logic             adr_ok;
  logic [IDX_W-1:0] reg_idx;

  // new cycle only while no ack is pending, so every ack is one cycle wide
  assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
  assign adr_ok  = (wb_adr < wb_addr_t'(N_REGS));
  assign reg_idx = wb_adr[IDX_W-1:0];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wb_ack <= 1'b0;
    end
    else
    begin
      wb_ack <= wb_req;
    end
  end

  // all slices come out of reset disabled
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      for (int i = 0; i < N_REGS; i++)
      begin
        slice_regs[i] <= '0;
      end
    end
    else if (wb_req && wb_we && adr_ok)
    begin
      slice_regs[reg_idx] <= wb_dat_w; // full word, no byte select
    end
  end

  // master holds the address until ack, so the read path can stay combinational
  always_comb
  begin
    if (adr_ok)
    begin
      wb_dat_r = slice_regs[reg_idx];
    end
    else
    begin
      wb_dat_r = '0; // unmapped words read back as zero
    end
  end

endmodule

/* rtl/rab_port_arbiter.sv */
module rab_port_arbiter
  import rab_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  virt_addr_t p1_addr,
  input  burst_len_t p1_len,
  input  beat_size_t p1_size,
  input  logic       p1_type,
  input  user_t      p1_user,
  input  logic       p1_addr_valid,
  input  virt_addr_t p2_addr,
  input  burst_len_t p2_len,
  input  beat_size_t p2_size,
  input  logic       p2_type,
  input  user_t      p2_user,
  input  logic       p2_addr_valid,
  input  logic       p1_served,
  input  logic       p2_served,
  output logic       select_p1,
  output logic       req_valid,
  output virt_addr_t addr_min,
  output virt_addr_t addr_max,
  output logic       req_write,
  output logic       req_prefetch
);

  logic       prio_p1; // port1 wins a tie when set
  virt_addr_t addr_sel;
  burst_len_t len_sel;
  beat_size_t size_sel;
  user_t      user_sel;
  virt_addr_t align_mask;
  virt_addr_t burst_bytes;

  assign select_p1 = (prio_p1 & p1_addr_valid) | ~p2_addr_valid;
  assign req_valid = p1_addr_valid | p2_addr_valid;

  assign addr_sel  = select_p1 ? p1_addr : p2_addr;
  assign len_sel   = select_p1 ? p1_len  : p2_len;
  assign size_sel  = select_p1 ? p1_size : p2_size;
  assign user_sel  = select_p1 ? p1_user : p2_user;
  assign req_write = select_p1 ? p1_type : p2_type;

  assign req_prefetch = (user_sel == {USER_WIDTH{1'b1}}); // all ones marks a prefetch

  // end address is computed from the beat aligned start
  always_comb
  begin
    case (size_sel)
      3'd1:    align_mask = ~virt_addr_t'(1);
      3'd2:    align_mask = ~virt_addr_t'(3);
      3'd3:    align_mask = ~virt_addr_t'(7);
      default: align_mask = '1;
    endcase
  end

  assign burst_bytes = (virt_addr_t'(len_sel) + virt_addr_t'(1)) << size_sel;
  assign addr_min    = addr_sel;
  assign addr_max    = (addr_sel & align_mask) + burst_bytes - virt_addr_t'(1);

  // priority moves to the other port once a port has been served
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      prio_p1 <= 1'b0;
    else if (p1_served)
      prio_p1 <= 1'b0;
    else if (p2_served)
      prio_p1 <= 1'b1;
  end

endmodule

/* rtl/rab_slice_lookup.sv */
module rab_slice_lookup
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  wb_data_t   slice_regs [REGS_PER_SLICE*N_SLICES],
  input  virt_addr_t addr_min,
  input  virt_addr_t addr_max,
  input  logic       req_write,
  output logic       hit,
  output logic       prot,
  output logic       multi_hit,
  output phys_addr_t xlat_addr
);

  logic [N_SLICES-1:0] hit_vec;
  logic [N_SLICES-1:0] prot_vec;
  phys_addr_t          xlat_vec [N_SLICES];

  for (genvar s = 0; s < N_SLICES; s++)
  begin : g_slice
    virt_addr_t start_s;
    virt_addr_t end_s;
    phys_addr_t offset_s;
    wb_data_t   flags_s;

    assign start_s  = slice_regs[REGS_PER_SLICE*s + SLICE_START][VIRT_ADDR_WIDTH-1:0];
    assign end_s    = slice_regs[REGS_PER_SLICE*s + SLICE_END][VIRT_ADDR_WIDTH-1:0];
    assign offset_s = slice_regs[REGS_PER_SLICE*s + SLICE_OFFSET][PHYS_ADDR_WIDTH-1:0];
    assign flags_s  = slice_regs[REGS_PER_SLICE*s + SLICE_FLAGS];

    // whole burst must sit inside the slice
    assign hit_vec[s] = flags_s[FLAG_EN] && (start_s <= addr_min) && (addr_max <= end_s);

    assign prot_vec[s] = hit_vec[s] &&
                         (req_write ? !flags_s[FLAG_WR] : !flags_s[FLAG_RD]);

    assign xlat_vec[s] = phys_addr_t'(addr_min - start_s) + offset_s;
  end

  assign hit  = |hit_vec;
  assign prot = |prot_vec;

  // clearing the lowest set bit leaves something only if two or more slices hit
  assign multi_hit = |(hit_vec & (hit_vec - 1'b1));

  always_comb
  begin
    xlat_addr = '0;
    for (int s = N_SLICES - 1; s >= 0; s--)
    begin
      if (hit_vec[s])
        xlat_addr = xlat_vec[s]; // lowest hitting slice is assigned last
    end
  end

endmodule

/* rtl/rab_fsm.sv */
module rab_fsm
  import rab_pkg::*;
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  logic       req_valid,
  input  logic       select_p1,
  input  logic       req_prefetch,
  input  logic       hit,
  input  logic       prot,
  input  logic       multi_hit,
  input  phys_addr_t xlat_addr,
  input  logic       p1_sent,
  input  logic       p2_sent,
  output logic       p1_accept,
  output logic       p1_drop,
  output logic       p2_accept,
  output logic       p2_drop,
  output phys_addr_t out_addr,
  output logic       int_miss,
  output logic       int_prot,
  output logic       int_multi,
  output logic       int_prefetch,
  output logic       p1_served,
  output logic       p2_served
);

  fsm_state_t state_q;
  logic       sel_q; // port owning the burst in flight
  logic       miss;

  assign miss      = !multi_hit && !hit;
  assign p1_served = p1_accept | p1_drop;
  assign p2_served = p2_accept | p2_drop;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q      <= IDLE;
      sel_q        <= 1'b0;
      p1_accept    <= 1'b0;
      p1_drop      <= 1'b0;
      p2_accept    <= 1'b0;
      p2_drop      <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;
      int_prefetch <= 1'b0;
      out_addr     <= '0;
    end
    else
    begin
      // handshake and interrupt outputs are single cycle pulses
      p1_accept    <= 1'b0;
      p1_drop      <= 1'b0;
      p2_accept    <= 1'b0;
      p2_drop      <= 1'b0;
      int_miss     <= 1'b0;
      int_prot     <= 1'b0;
      int_multi    <= 1'b0;
      int_prefetch <= 1'b0;

      case (state_q)
        IDLE:
        begin
          // a dropped request is still valid during its drop pulse
          if (req_valid && !(p1_served || p2_served))
            state_q <= DECIDE;
        end
        DECIDE:
        begin
          sel_q <= select_p1;
          if (multi_hit || !hit || prot)
          begin
            p1_drop      <= select_p1;
            p2_drop      <= !select_p1;
            int_multi    <= multi_hit;
            int_prefetch <= miss && req_prefetch;
            int_miss     <= miss && !req_prefetch;
            int_prot     <= !multi_hit && hit && prot;
            state_q      <= IDLE;
          end
          else
          begin
            p1_accept <= select_p1;
            p2_accept <= !select_p1;
            out_addr  <= xlat_addr; // held until the next accept
            state_q   <= WAIT_SENT;
          end
        end
        WAIT_SENT:
        begin
          if (sel_q ? p1_sent : p2_sent)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/rab_core.sv */
module rab_core
  import rab_pkg::*;
#(
  parameter int N_SLICES = 4
)
(
  input  logic       Clk_CI,
  input  logic       Rst_RBI,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_addr_t   wb_adr,
  input  wb_data_t   wb_dat_w,
  output wb_data_t   wb_dat_r,
  output logic       wb_ack,
  input  virt_addr_t p1_addr,
  input  burst_len_t p1_len,
  input  beat_size_t p1_size,
  input  logic       p1_type,
  input  user_t      p1_user,
  input  logic       p1_addr_valid,
  input  logic       p1_sent,
  output logic       p1_accept,
  output logic       p1_drop,
  input  virt_addr_t p2_addr,
  input  burst_len_t p2_len,
  input  beat_size_t p2_size,
  input  logic       p2_type,
  input  user_t      p2_user,
  input  logic       p2_addr_valid,
  input  logic       p2_sent,
  output logic       p2_accept,
  output logic       p2_drop,
  output phys_addr_t out_addr,
  output logic       int_miss,
  output logic       int_prot,
  output logic       int_multi,
  output logic       int_prefetch
);

  wb_data_t   slice_regs [REGS_PER_SLICE*N_SLICES];
  logic       select_p1;
  logic       req_valid;
  virt_addr_t addr_min;
  virt_addr_t addr_max;
  logic       req_write;
  logic       req_prefetch;
  logic       hit;
  logic       prot;
  logic       multi_hit;
  phys_addr_t xlat_addr;
  logic       p1_served;
  logic       p2_served;

  rab_cfg_regs #(
    .N_SLICES ( N_SLICES )
  ) u_cfg_regs (
    .Clk_CI     ( Clk_CI     ),
    .Rst_RBI    ( Rst_RBI    ),
    .wb_cyc     ( wb_cyc     ),
    .wb_stb     ( wb_stb     ),
    .wb_we      ( wb_we      ),
    .wb_adr     ( wb_adr     ),
    .wb_dat_w   ( wb_dat_w   ),
    .wb_dat_r   ( wb_dat_r   ),
    .wb_ack     ( wb_ack     ),
    .slice_regs ( slice_regs )
  );

  rab_port_arbiter u_port_arbiter (
    .Clk_CI        ( Clk_CI        ),
    .Rst_RBI       ( Rst_RBI       ),
    .p1_addr       ( p1_addr       ),
    .p1_len        ( p1_len        ),
    .p1_size       ( p1_size       ),
    .p1_type       ( p1_type       ),
    .p1_user       ( p1_user       ),
    .p1_addr_valid ( p1_addr_valid ),
    .p2_addr       ( p2_addr       ),
    .p2_len        ( p2_len        ),
    .p2_size       ( p2_size       ),
    .p2_type       ( p2_type       ),
    .p2_user       ( p2_user       ),
    .p2_addr_valid ( p2_addr_valid ),
    .p1_served     ( p1_served     ),
    .p2_served     ( p2_served     ),
    .select_p1     ( select_p1     ),
    .req_valid     ( req_valid     ),
    .addr_min      ( addr_min      ),
    .addr_max      ( addr_max      ),
    .req_write     ( req_write     ),
    .req_prefetch  ( req_prefetch  )
  );

  rab_slice_lookup #(
    .N_SLICES ( N_SLICES )
  ) u_slice_lookup (
    .slice_regs ( slice_regs ),
    .addr_min   ( addr_min   ),
    .addr_max   ( addr_max   ),
    .req_write  ( req_write  ),
    .hit        ( hit        ),
    .prot       ( prot       ),
    .multi_hit  ( multi_hit  ),
    .xlat_addr  ( xlat_addr  )
  );

  rab_fsm u_fsm (
    .Clk_CI       ( Clk_CI       ),
    .Rst_RBI      ( Rst_RBI      ),
    .req_valid    ( req_valid    ),
    .select_p1    ( select_p1    ),
    .req_prefetch ( req_prefetch ),
    .hit          ( hit          ),
    .prot         ( prot         ),
    .multi_hit    ( multi_hit    ),
    .xlat_addr    ( xlat_addr    ),
    .p1_sent      ( p1_sent      ),
    .p2_sent      ( p2_sent      ),
    .p1_accept    ( p1_accept    ),
    .p1_drop      ( p1_drop      ),
    .p2_accept    ( p2_accept    ),
    .p2_drop      ( p2_drop      ),
    .out_addr     ( out_addr     ),
    .int_miss     ( int_miss     ),
    .int_prot     ( int_prot     ),
    .int_multi    ( int_multi    ),
    .int_prefetch ( int_prefetch ),
    .p1_served    ( p1_served    ),
    .p2_served    ( p2_served    )
  );

endmodule

/* dv/rab_core_properties.sv */
module rab_core_properties
  import rab_pkg::*;
(
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic p1_accept,
  input logic p1_drop,
  input logic p2_accept,
  input logic p2_drop,
  input logic int_miss,
  input logic int_prot,
  input logic int_multi,
  input logic int_prefetch
);

  logic any_accept;
  logic any_drop;
  logic any_int;

  assign any_accept = p1_accept | p2_accept;
  assign any_drop   = p1_drop | p2_drop;
  assign any_int    = int_miss | int_prot | int_multi | int_prefetch;

  // new Wishbone request gets its ack on the next edge
  ack_follows_request: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else $error("wb_ack missing one cycle after a new request");

  ack_one_cycle: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wb_ack |=> !wb_ack)
    else $error("wb_ack longer than one cycle");

  ack_needs_request: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
    else $error("wb_ack without a preceding request");

  one_decision: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    $onehot0({p1_accept, p1_drop, p2_accept, p2_drop}))
    else $error("more than one accept or drop in the same cycle");

  quiet_accept: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    any_accept |-> !any_int)
    else $error("interrupt together with an accept");

  drop_has_one_int: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    any_drop |-> $onehot({int_miss, int_prot, int_multi, int_prefetch}))
    else $error("drop without exactly one interrupt");

  int_needs_drop: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    any_int |-> any_drop)
    else $error("interrupt without a drop");

endmodule

bind rab_core rab_core_properties u_properties (
  .Clk_CI       ( Clk_CI       ),
  .Rst_RBI      ( Rst_RBI      ),
  .wb_cyc       ( wb_cyc       ),
  .wb_stb       ( wb_stb       ),
  .wb_ack       ( wb_ack       ),
  .p1_accept    ( p1_accept    ),
  .p1_drop      ( p1_drop      ),
  .p2_accept    ( p2_accept    ),
  .p2_drop      ( p2_drop      ),
  .int_miss     ( int_miss     ),
  .int_prot     ( int_prot     ),
  .int_multi    ( int_multi    ),
  .int_prefetch ( int_prefetch )
);

/* dv/tb_rab_core.sv */
module tb_rab_core
  import rab_pkg::*;
();

  localparam int N_SLICES       = 4;
  localparam int N_REGS         = REGS_PER_SLICE * N_SLICES;
  localparam int TIMEOUT_CYCLES = 2000;

  // outcome codes of one request
  localparam int OUT_NONE     = -1;
  localparam int OUT_ACCEPT   = 0;
  localparam int OUT_MULTI    = 1;
  localparam int OUT_MISS     = 2;
  localparam int OUT_PREFETCH = 3;
  localparam int OUT_PROT     = 4;

  logic       Clk_CI;
  logic       Rst_RBI;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  virt_addr_t p1_addr;
  burst_len_t p1_len;
  beat_size_t p1_size;
  logic       p1_type;
  user_t      p1_user;
  logic       p1_addr_valid;
  logic       p1_sent;
  logic       p1_accept;
  logic       p1_drop;
  virt_addr_t p2_addr;
  burst_len_t p2_len;
  beat_size_t p2_size;
  logic       p2_type;
  user_t      p2_user;
  logic       p2_addr_valid;
  logic       p2_sent;
  logic       p2_accept;
  logic       p2_drop;
  phys_addr_t out_addr;
  logic       int_miss;
  logic       int_prot;
  logic       int_multi;
  logic       int_prefetch;

  wb_data_t ref_regs [N_REGS]; // expected register contents
  integer   seed;
  int       cycle_cnt;

  rab_core #(
    .N_SLICES ( N_SLICES )
  ) DUT (
    .Clk_CI        ( Clk_CI        ),
    .Rst_RBI       ( Rst_RBI       ),
    .wb_cyc        ( wb_cyc        ),
    .wb_stb        ( wb_stb        ),
    .wb_we         ( wb_we         ),
    .wb_adr        ( wb_adr        ),
    .wb_dat_w      ( wb_dat_w      ),
    .wb_dat_r      ( wb_dat_r      ),
    .wb_ack        ( wb_ack        ),
    .p1_addr       ( p1_addr       ),
    .p1_len        ( p1_len        ),
    .p1_size       ( p1_size       ),
    .p1_type       ( p1_type       ),
    .p1_user       ( p1_user       ),
    .p1_addr_valid ( p1_addr_valid ),
    .p1_sent       ( p1_sent       ),
    .p1_accept     ( p1_accept     ),
    .p1_drop       ( p1_drop       ),
    .p2_addr       ( p2_addr       ),
    .p2_len        ( p2_len        ),
    .p2_size       ( p2_size       ),
    .p2_type       ( p2_type       ),
    .p2_user       ( p2_user       ),
    .p2_addr_valid ( p2_addr_valid ),
    .p2_sent       ( p2_sent       ),
    .p2_accept     ( p2_accept     ),
    .p2_drop       ( p2_drop       ),
    .out_addr      ( out_addr      ),
    .int_miss      ( int_miss      ),
    .int_prot      ( int_prot      ),
    .int_multi     ( int_multi     ),
    .int_prefetch  ( int_prefetch  )
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever #20 Clk_CI = ~Clk_CI;
  end

  always @(posedge Clk_CI)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic report_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic write_reg(wb_addr_t adr, wb_data_t data);
    @(posedge Clk_CI);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    do
    begin
      @(negedge Clk_CI);
    end
    while (!wb_ack);
    @(posedge Clk_CI);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (adr < wb_addr_t'(N_REGS))
      ref_regs[adr] = data; // unmapped words keep reading zero
  endtask

  task automatic read_reg(wb_addr_t adr, output wb_data_t data);
    @(posedge Clk_CI);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do
    begin
      @(negedge Clk_CI);
    end
    while (!wb_ack);
    data = wb_dat_r; // valid while ack is high
    @(posedge Clk_CI);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic check_readback(wb_addr_t adr);
    wb_data_t got;
    wb_data_t exp;
    read_reg(adr, got);
    exp = (adr < wb_addr_t'(N_REGS)) ? ref_regs[adr] : '0;
    assert (got == exp)
    else report_error($sformatf("register %0d reads %h, expected %h", adr, got, exp));
  endtask

  task automatic program_slice(int s, virt_addr_t first, virt_addr_t last,
                               phys_addr_t offset, wb_data_t flags);
    write_reg(wb_addr_t'(REGS_PER_SLICE*s + SLICE_START), wb_data_t'(first));
    write_reg(wb_addr_t'(REGS_PER_SLICE*s + SLICE_END), wb_data_t'(last));
    write_reg(wb_addr_t'(REGS_PER_SLICE*s + SLICE_OFFSET), wb_data_t'(offset));
    write_reg(wb_addr_t'(REGS_PER_SLICE*s + SLICE_FLAGS), flags);
  endtask

  // expected outcome from the slice contents written so far
  function automatic int predict_outcome(virt_addr_t addr, burst_len_t len, beat_size_t size,
                                         logic write, user_t user, output phys_addr_t phys);
    virt_addr_t last;
    virt_addr_t s_first;
    virt_addr_t s_last;
    wb_data_t   flags;
    int         hits;
    logic       denied;
    phys   = '0;
    hits   = 0;
    denied = 1'b0;
    last   = ((addr >> size) << size) + ((virt_addr_t'(len) + 1) << size) - 1;
    for (int s = 0; s < N_SLICES; s++)
    begin
      s_first = ref_regs[REGS_PER_SLICE*s + SLICE_START][VIRT_ADDR_WIDTH-1:0];
      s_last  = ref_regs[REGS_PER_SLICE*s + SLICE_END][VIRT_ADDR_WIDTH-1:0];
      flags   = ref_regs[REGS_PER_SLICE*s + SLICE_FLAGS];
      if (flags[FLAG_EN] && s_first <= addr && last <= s_last)
      begin
        if (hits == 0) // lowest slice translates
          phys = phys_addr_t'(addr - s_first) +
                 ref_regs[REGS_PER_SLICE*s + SLICE_OFFSET][PHYS_ADDR_WIDTH-1:0];
        hits++;
        denied = denied | (write ? !flags[FLAG_WR] : !flags[FLAG_RD]);
      end
    end
    if (hits > 1)
      return OUT_MULTI;
    if (hits == 0)
      return (user == '1) ? OUT_PREFETCH : OUT_MISS;
    if (denied)
      return OUT_PROT;
    return OUT_ACCEPT;
  endfunction

  task automatic set_port(int port, virt_addr_t addr, burst_len_t len, beat_size_t size,
                          logic write, user_t user, logic valid);
    if (port == 1)
    begin
      p1_addr       <= addr;
      p1_len        <= len;
      p1_size       <= size;
      p1_type       <= write;
      p1_user       <= user;
      p1_addr_valid <= valid;
    end
    else
    begin
      p2_addr       <= addr;
      p2_len        <= len;
      p2_size       <= size;
      p2_type       <= write;
      p2_user       <= user;
      p2_addr_valid <= valid;
    end
  endtask

  // returns at the falling edge where an accept or drop is seen
  task automatic wait_served(output int port, output int outcome, output phys_addr_t addr,
                             output int cycles);
    cycles = 0;
    do
    begin
      @(negedge Clk_CI);
      cycles++;
    end
    while (!(p1_accept | p1_drop | p2_accept | p2_drop));
    port = (p1_accept | p1_drop) ? 1 : 2;
    addr = out_addr;
    if (p1_accept | p2_accept)
      outcome = OUT_ACCEPT;
    else if (int_multi)
      outcome = OUT_MULTI;
    else if (int_prefetch)
      outcome = OUT_PREFETCH;
    else if (int_miss)
      outcome = OUT_MISS;
    else if (int_prot)
      outcome = OUT_PROT;
    else
      outcome = OUT_NONE;
  endtask

  task automatic check_result(int exp_port, int exp_outcome, phys_addr_t exp_addr,
                              int got_port, int got_outcome, phys_addr_t got_addr);
    assert (got_port == exp_port)
    else report_error($sformatf("port %0d served, expected port %0d", got_port, exp_port));
    assert (got_outcome == exp_outcome)
    else report_error($sformatf("outcome %0d, expected %0d", got_outcome, exp_outcome));
    if (exp_outcome == OUT_ACCEPT)
    begin
      assert (got_addr == exp_addr)
      else report_error($sformatf("out_addr %h, expected %h", got_addr, exp_addr));
    end
  endtask

  task automatic issue_request(int port, virt_addr_t addr, burst_len_t len, beat_size_t size,
                               logic write, user_t user);
    int         exp_outcome;
    phys_addr_t exp_addr;
    int         got_port;
    int         got_outcome;
    phys_addr_t got_addr;
    int         cycles;
    exp_outcome = predict_outcome(addr, len, size, write, user, exp_addr);
    @(posedge Clk_CI);
    set_port(port, addr, len, size, write, user, 1'b1);
    @(posedge Clk_CI); // request sampled in IDLE here
    wait_served(got_port, got_outcome, got_addr, cycles);
    assert (cycles == 2)
    else report_error($sformatf("decision after %0d cycles, expected 2", cycles));
    check_result(port, exp_outcome, exp_addr, got_port, got_outcome, got_addr);
    @(posedge Clk_CI);
    set_port(port, addr, len, size, write, user, 1'b0);
    if (got_outcome == OUT_ACCEPT)
    begin
      if (port == 1)
        p1_sent <= 1'b1;
      else
        p2_sent <= 1'b1;
      @(posedge Clk_CI);
      p1_sent <= 1'b0;
      p2_sent <= 1'b0;
    end
  endtask

  // both ports stay valid, port1 as prefetch so the two outcomes differ
  task automatic check_alternation(int rounds);
    int         exp_port;
    int         exp_outcome;
    phys_addr_t exp_addr;
    int         got_port;
    int         got_outcome;
    phys_addr_t got_addr;
    int         cycles;
    @(posedge Clk_CI);
    set_port(1, 32'h4000_0000, 8'd3, 3'd2, 1'b0, '1, 1'b1);
    set_port(2, 32'h5000_0000, 8'd0, 3'd3, 1'b0, user_t'(5), 1'b1);
    exp_port = 2; // port2 owns priority after reset
    for (int r = 0; r < rounds; r++)
    begin
      if (exp_port == 1)
        exp_outcome = predict_outcome(32'h4000_0000, 8'd3, 3'd2, 1'b0, '1, exp_addr);
      else
        exp_outcome = predict_outcome(32'h5000_0000, 8'd0, 3'd3, 1'b0, user_t'(5), exp_addr);
      wait_served(got_port, got_outcome, got_addr, cycles);
      check_result(exp_port, exp_outcome, exp_addr, got_port, got_outcome, got_addr);
      exp_port = 3 - exp_port;
    end
    @(posedge Clk_CI);
    p1_addr_valid <= 1'b0;
    p2_addr_valid <= 1'b0;
  endtask

  initial
  begin
    virt_addr_t rnd_addr;
    burst_len_t rnd_len;
    beat_size_t rnd_size;
    seed      = 32'hcdc2_d94a;
    cycle_cnt = 0;
    Rst_RBI   = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    p1_sent   = 1'b0;
    p2_sent   = 1'b0;
    set_port(1, '0, '0, '0, 1'b0, '0, 1'b0);
    set_port(2, '0, '0, '0, 1'b0, '0, 1'b0);
    for (int i = 0; i < N_REGS; i++)
      ref_regs[i] = '0;
    repeat (4) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;
    @(negedge Clk_CI);
    assert (!p1_accept && !p1_drop && !p2_accept && !p2_drop && !wb_ack && out_addr == '0)
    else report_error("outputs not idle after reset");
    assert (!int_miss && !int_prot && !int_multi && !int_prefetch)
    else report_error("interrupt active after reset");

    check_alternation(4); // all slices still disabled, so every request drops

    program_slice(0, 32'h1000_0000, 32'h1000_ffff, 40'h12_3400_0000, 64'h3); // read only
    program_slice(1, 32'h2000_0000, 32'h2000_0fff, 40'h00_4000_0000, 64'h7);
    program_slice(2, 32'h2000_0000, 32'h2000_03ff, 40'h00_9000_0000, 64'h7); // overlaps slice 1
    write_reg(wb_addr_t'(N_REGS), 64'hdead_beef_0000_0001);
    write_reg(8'hff, 64'h0123_4567_89ab_cdef);
    for (int a = 0; a < N_REGS + 2; a++)
      check_readback(wb_addr_t'(a));
    check_readback(8'hff);

    for (int i = 0; i < 6; i++)
    begin
      rnd_addr = 32'h1000_0000 + (virt_addr_t'($random(seed)) & 32'h7fff);
      rnd_len  = burst_len_t'($random(seed) & 15);
      rnd_size = beat_size_t'($random(seed) & 3);
      issue_request(1 + (i % 2), rnd_addr, rnd_len, rnd_size, 1'b0, user_t'(i));
    end
    issue_request(1, 32'h1000_0100, 8'd1, 3'd2, 1'b1, '0);        // write into read only
    issue_request(2, 32'h2000_0800, 8'd7, 3'd3, 1'b1, '0);        // write inside slice 1
    issue_request(1, 32'h2000_0f04, 8'd63, 3'd3, 1'b0, '0);       // end passes slice 1
    issue_request(2, 32'h2000_0f04, 8'd63, 3'd3, 1'b0, '1);       // same as prefetch
    issue_request(1, 32'h2000_0100, 8'd3, 3'd2, 1'b0, user_t'(2)); // slices 1 and 2

    repeat (2) @(posedge Clk_CI);
    $display("test passed");
    $finish;
  end

endmodule

/* tb.f */
rtl/rab_pkg.sv
rtl/rab_cfg_regs.sv
rtl/rab_port_arbiter.sv
rtl/rab_slice_lookup.sv
rtl/rab_fsm.sv
rtl/rab_core.sv
dv/rab_core_properties.sv
dv/tb_rab_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rab_core
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
FAIL_MSG   := test failed
PASS_MSG   := test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
